/* verilog/mrdma_ig_pkg.sv */
// shared widths, types and bus payloads for the mrdma ingress request generator
// addresses inside the block are 16-byte atom addresses; only the dma port carries bytes
package mrdma_ig_pkg;

  // ====================
  // widths
  // ====================
  // low address bits dropped, 16-byte atoms
  localparam int ATOM_SHIFT  = 4;
  localparam int DMA_ADDR_W  = 64;
  localparam int ELEM_ADDR_W = DMA_ADDR_W - ATOM_SHIFT;
  localparam int STRIDE_W    = 28;
  localparam int DIM_W       = 13;
  localparam int CHAN_BLK_W  = 10;
  localparam int REQ_SIZE_W  = 15;
  localparam int CQ_SIZE_W   = 13;
  localparam int STALL_W     = 32;

  // ====================
  // vector types
  // ====================
  typedef logic [DMA_ADDR_W-1:0]  dma_addr_t;
  typedef logic [ELEM_ADDR_W-1:0] elem_addr_t;
  // strides in atoms
  typedef logic [STRIDE_W-1:0]    stride_t;
  // cube dims, count minus one
  typedef logic [DIM_W-1:0]       dim_t;
  typedef logic [CHAN_BLK_W-1:0]  chan_blk_t;
  // size in atoms minus one
  typedef logic [REQ_SIZE_W-1:0]  req_size_t;
  typedef logic [STALL_W-1:0]     stall_cnt_t;

  // input data precision, encoding as in the register file
  typedef enum logic [1:0] {
    PREC_INT8  = 2'd0,
    PREC_INT16 = 2'd1,
    PREC_FP16  = 2'd2
  } precision_e;

  // ====================
  // structs
  // ====================
  // per-operation config, static while the op runs
  typedef struct packed {
    elem_addr_t base_addr;
    stride_t    line_stride;
    stride_t    surf_stride;
    dim_t       width;
    dim_t       height;
    dim_t       channel;
    precision_e in_precision;
    logic       perf_dma_en;
  } mrdma_cfg_t;

  // dma read request, size on top, byte address below
  typedef struct packed {
    req_size_t size;
    dma_addr_t addr;
  } dma_rd_req_t;

  // context queue entry
  typedef struct packed {
    logic                 cube_end;
    logic [CQ_SIZE_W-1:0] size;
  } ig2cq_t;

endpackage

/* verilog/mrdma_cube_walker.sv */
// walks lines, then channel surfaces, of one cube; one request per line
// no batch walking, every accepted request ends a line
`timescale 1ns/1ps

module mrdma_cube_walker import mrdma_ig_pkg::*; (
  input  logic       nvdla_core_clk,
  input  logic       nvdla_core_rstn,
  input  mrdma_cfg_t cfg,
  input  logic       cmd_accept,
  output logic       surf_end,
  output logic       cube_end,
  output req_size_t  req_size
);

  logic      mode_1x1_pack;
  chan_blk_t size_of_surf;
  dim_t      count_h;
  chan_blk_t count_c;
  logic      is_last_h;
  logic      is_last_c;

  // ====================
  // config decode
  // ====================
  // width and height both one => whole cube in a single request
  assign mode_1x1_pack = (cfg.width == '0) && (cfg.height == '0);

  // channel blocks minus one
  // int8 packs 16 channels per atom and the rest 8
  always_comb begin
    case (cfg.in_precision)
      PREC_INT8: size_of_surf = {1'b0, cfg.channel[DIM_W-1:4]};
      default:   size_of_surf = cfg.channel[DIM_W-1:3];
    endcase
  end

  // ====================
  // cube shape
  // ====================
  assign is_last_h = (count_h == cfg.height);
  assign is_last_c = (count_c == size_of_surf);
  assign surf_end  = mode_1x1_pack || is_last_h;
  assign cube_end  = surf_end && (mode_1x1_pack || is_last_c);

  // line counter returns to zero at each surface end
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      count_h <= '0;
    end else if (cmd_accept) begin
      if (surf_end) begin
        count_h <= '0;
      end else begin
        count_h <= count_h + dim_t'(1);
      end
    end
  end

  // channel block counter steps once per surface
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      count_c <= '0;
    end else if (cmd_accept) begin
      if (cube_end) begin
        count_c <= '0;
      end else if (surf_end) begin
        count_c <= count_c + chan_blk_t'(1);
      end
    end
  end

  // ====================
  // request size
  // ====================
  // 1x1 pack reads all channel blocks at once and otherwise one full line
  assign req_size = mode_1x1_pack ? req_size_t'(size_of_surf) : req_size_t'(cfg.width);

endmodule

/* verilog/mrdma_addr_gen.sv */
// line and surface base address tracking, all in atoms
// address wrap past 60 bits is not detected
`timescale 1ns/1ps

module mrdma_addr_gen import mrdma_ig_pkg::*; (
  input  logic       nvdla_core_clk,
  input  logic       nvdla_core_rstn,
  input  logic       op_load,
  input  logic       cmd_accept,
  input  logic       surf_end,
  input  mrdma_cfg_t cfg,
  output elem_addr_t req_addr
);

  elem_addr_t base_addr_line;
  elem_addr_t base_addr_surf;
  elem_addr_t next_surf_addr;
  elem_addr_t next_line_addr;
  logic       load_cfg;

  // ====================
  // next addresses
  // ====================
  // strides zero-extended to the atom address width
  assign next_surf_addr = base_addr_surf + elem_addr_t'(cfg.surf_stride);
  assign next_line_addr = base_addr_line + elem_addr_t'(cfg.line_stride);

  // load wins over a same-cycle accept
  assign load_cfg = op_load;

  // ====================
  // base registers
  // ====================
  // line base holds the start of the line being requested
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      base_addr_line <= '0;
    end else if (load_cfg) begin
      base_addr_line <= cfg.base_addr;
    end else if (cmd_accept) begin
      if (surf_end) begin
        // first line of the next surface
        base_addr_line <= next_surf_addr;
      end else begin
        base_addr_line <= next_line_addr;
      end
    end
  end

  // surface base holds the start of the current surface
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      base_addr_surf <= '0;
    end else if (load_cfg) begin
      base_addr_surf <= cfg.base_addr;
    end else if (cmd_accept && surf_end) begin
      base_addr_surf <= next_surf_addr;
    end
  end

  // request goes out at the line base
  assign req_addr = base_addr_line;

endmodule

/* verilog/mrdma_req_issue.sv */
// issues the dma read and the matching context queue entry as one transfer
// each valid waits on the other side's ready, so both accept in the same cycle
`timescale 1ns/1ps

module mrdma_req_issue import mrdma_ig_pkg::*; (
  input  logic        nvdla_core_clk,
  input  logic        nvdla_core_rstn,
  input  logic        op_load,
  input  elem_addr_t  req_addr,
  input  req_size_t   req_size,
  input  logic        cube_end,
  output logic        dma_rd_req_vld,
  input  logic        dma_rd_req_rdy,
  output dma_rd_req_t dma_rd_req_pd,
  output logic        ig2cq_pvld,
  input  logic        ig2cq_prdy,
  output ig2cq_t      ig2cq_pd,
  output logic        cmd_accept
);

  typedef enum logic {
    ST_IDLE   = 1'b0,
    ST_ACTIVE = 1'b1
  } issue_state_e;

  issue_state_e state;
  issue_state_e state_nxt;
  logic         op_active;
  logic         cmd_done;

  // ====================
  // op state
  // ====================
  // last request of the cube accepted
  assign cmd_done = cmd_accept && cube_end;

  always_comb begin
    state_nxt = state;
    if (op_load) begin
      state_nxt = ST_ACTIVE;
    end else if (cmd_done) begin
      state_nxt = ST_IDLE;
    end
  end

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      state <= ST_IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  assign op_active = (state == ST_ACTIVE);

  // ====================
  // paired handshake
  // ====================
  // dma valid held back until cq can take the entry
  assign dma_rd_req_vld = op_active && ig2cq_prdy;
  // and the other way round
  assign ig2cq_pvld = op_active && dma_rd_req_rdy;

  // equal to the cq side accept by construction
  assign cmd_accept = dma_rd_req_vld && dma_rd_req_rdy;

  // ====================
  // payload packing
  // ====================
  // atom address back to bytes
  assign dma_rd_req_pd.addr = dma_addr_t'(req_addr) << ATOM_SHIFT;
  assign dma_rd_req_pd.size = req_size;

  // cq keeps only the low size bits
  assign ig2cq_pd.cube_end = cube_end;
  assign ig2cq_pd.size     = req_size[CQ_SIZE_W-1:0];

endmodule

/* verilog/mrdma_stall_cnt.sv */
// counts cycles where the dma port holds off a valid request
// enabled per op from perf_dma_en at load; wraps at 32 bits, no decrement
`timescale 1ns/1ps

module mrdma_stall_cnt import mrdma_ig_pkg::*; (
  input  logic       nvdla_core_clk,
  input  logic       nvdla_core_rstn,
  input  logic       op_load,
  input  logic       perf_dma_en,
  input  logic       dma_rd_req_vld,
  input  logic       dma_rd_req_rdy,
  output stall_cnt_t stall_cnt
);

  logic       cnt_en;
  logic       stall_inc;
  stall_cnt_t cnt_cur;

  // valid up, port not ready
  assign stall_inc = dma_rd_req_vld && !dma_rd_req_rdy;

  // enable sampled once per op
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      cnt_en <= 1'b0;
    end else if (op_load) begin
      cnt_en <= perf_dma_en;
    end
  end

  // clear only when the new op counts, so a disabled op keeps the old value
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      cnt_cur <= '0;
    end else if (op_load) begin
      if (perf_dma_en) begin
        cnt_cur <= '0;
      end
    end else if (cnt_en && stall_inc) begin
      cnt_cur <= cnt_cur + stall_cnt_t'(1);
    end
  end

  assign stall_cnt = cnt_cur;

endmodule

/* verilog/mrdma_ig.sv */
// mrdma ingress request generator, one dma read per line of the feature cube
// cfg must stay stable from op_load until the cube_end request is accepted
// next op_load only while idle
`timescale 1ns/1ps

module mrdma_ig import mrdma_ig_pkg::*; (
  input  logic        nvdla_core_clk,
  input  logic        nvdla_core_rstn,
  input  logic        op_load,
  input  mrdma_cfg_t  cfg,
  // dma read request port
  output dma_rd_req_t dma_rd_req_pd,
  output logic        dma_rd_req_vld,
  input  logic        dma_rd_req_rdy,
  // context queue port
  output ig2cq_t      ig2cq_pd,
  output logic        ig2cq_pvld,
  input  logic        ig2cq_prdy,
  // perf counter
  output stall_cnt_t  dp2reg_mrdma_stall
);

  logic       cmd_accept;
  logic       surf_end;
  logic       cube_end;
  req_size_t  req_size;
  elem_addr_t req_addr;

  // ====================
  // request fields
  // ====================
  // position in the cube and the size of the current request
  mrdma_cube_walker u_cube_walker (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .cfg             (cfg),
    .cmd_accept      (cmd_accept),
    .surf_end        (surf_end),
    .cube_end        (cube_end),
    .req_size        (req_size)
  );

  // atom address of the current request
  mrdma_addr_gen u_addr_gen (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .op_load         (op_load),
    .cmd_accept      (cmd_accept),
    .surf_end        (surf_end),
    .cfg             (cfg),
    .req_addr        (req_addr)
  );

  // ====================
  // issue
  // ====================
  mrdma_req_issue u_req_issue (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .op_load         (op_load),
    .req_addr        (req_addr),
    .req_size        (req_size),
    .cube_end        (cube_end),
    .dma_rd_req_vld  (dma_rd_req_vld),
    .dma_rd_req_rdy  (dma_rd_req_rdy),
    .dma_rd_req_pd   (dma_rd_req_pd),
    .ig2cq_pvld      (ig2cq_pvld),
    .ig2cq_prdy      (ig2cq_prdy),
    .ig2cq_pd        (ig2cq_pd),
    .cmd_accept      (cmd_accept)
  );

  // ====================
  // perf
  // ====================
  mrdma_stall_cnt u_stall_cnt (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .op_load         (op_load),
    .perf_dma_en     (cfg.perf_dma_en),
    .dma_rd_req_vld  (dma_rd_req_vld),
    .dma_rd_req_rdy  (dma_rd_req_rdy),
    .stall_cnt       (dp2reg_mrdma_stall)
  );

endmodule

/* verif/tb_mrdma_ig.sv */
// testbench for mrdma_ig; rdy inputs come from a 32-bit lfsr, seed 32'hbab0
// reference walk built per op from cfg; one op at a time, next load only once idle
`timescale 1ns/1ps

module tb_mrdma_ig import mrdma_ig_pkg::*; ();

  logic        nvdla_core_clk = 1'b0;
  logic        nvdla_core_rstn;
  logic        op_load;
  mrdma_cfg_t  cfg;
  dma_rd_req_t dma_rd_req_pd;
  logic        dma_rd_req_vld;
  logic        dma_rd_req_rdy = 1'b0;
  ig2cq_t      ig2cq_pd;
  logic        ig2cq_pvld;
  logic        ig2cq_prdy = 1'b0;
  stall_cnt_t  dp2reg_mrdma_stall;

  // model state
  dma_rd_req_t exp_req_q[$];
  logic        exp_end_q[$];
  mrdma_cfg_t  op_cfg[$];
  logic        expect_idle = 1'b1;
  stall_cnt_t  stall_cycles = '0;
  stall_cnt_t  stall_before = '0;
  logic [31:0] lfsr_state = 32'hbab0;
  logic        rnd_a;
  logic        rnd_b;
  logic        rnd_c;
  logic        rnd_d;
  logic        dma_acc;
  logic        cq_acc;
  int          errors = 0;
  int          requests = 0;
  int          ops = 0;
  int          watchdog_cycles = 0;

  mrdma_ig i_mrdma_ig (
    .nvdla_core_clk     (nvdla_core_clk),
    .nvdla_core_rstn    (nvdla_core_rstn),
    .op_load            (op_load),
    .cfg                (cfg),
    .dma_rd_req_pd      (dma_rd_req_pd),
    .dma_rd_req_vld     (dma_rd_req_vld),
    .dma_rd_req_rdy     (dma_rd_req_rdy),
    .ig2cq_pd           (ig2cq_pd),
    .ig2cq_pvld         (ig2cq_pvld),
    .ig2cq_prdy         (ig2cq_prdy),
    .dp2reg_mrdma_stall (dp2reg_mrdma_stall)
  );

  always #2 nvdla_core_clk = ~nvdla_core_clk;

  // ====================
  // helpers
  // ====================
  // fibonacci lfsr with taps 32 22 2 1 and one step per bit
  task automatic draw_bit(output logic b);
    lfsr_state = {lfsr_state[30:0],
                  lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
    b = lfsr_state[0];
  endtask

  task automatic report_mismatch(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
    errors++;
    $display("Error %s got %h expected %h at %0t", name, got, exp, $time);
  endtask

  function automatic mrdma_cfg_t make_cfg(input elem_addr_t base, input stride_t line_s,
                                          input stride_t surf_s, input dim_t w,
                                          input dim_t h, input dim_t ch,
                                          input precision_e prec);
    mrdma_cfg_t c;
    c = '0;
    c.base_addr = base;
    c.line_stride = line_s;
    c.surf_stride = surf_s;
    c.width = w;
    c.height = h;
    c.channel = ch;
    c.in_precision = prec;
    return c;
  endfunction

  // channel blocks minus one with 16 channels per atom for int8 and 8 otherwise
  function automatic int chan_blocks(input mrdma_cfg_t c);
    if (c.in_precision == PREC_INT8) begin
      return int'(c.channel) / 16;
    end
    return int'(c.channel) / 8;
  endfunction

  function automatic logic is_pack_1x1(input mrdma_cfg_t c);
    return (c.width == '0) && (c.height == '0);
  endfunction

  function automatic int count_requests(input mrdma_cfg_t c);
    if (is_pack_1x1(c)) begin
      return 1;
    end
    return (chan_blocks(c) + 1) * (int'(c.height) + 1);
  endfunction

  // ====================
  // reference walk
  // ====================
  // line h of surface b sits at base + b*surf_stride + h*line_stride
  task automatic build_expected(input mrdma_cfg_t c);
    int          nblk;
    dma_rd_req_t r;
    elem_addr_t  a;
    exp_req_q.delete();
    exp_end_q.delete();
    nblk = chan_blocks(c);
    if (is_pack_1x1(c)) begin
      r.addr = {c.base_addr, {ATOM_SHIFT{1'b0}}};
      r.size = req_size_t'(nblk);
      exp_req_q.push_back(r);
      exp_end_q.push_back(1'b1);
    end else begin
      for (int b = 0; b <= nblk; b++) begin
        for (int h = 0; h <= int'(c.height); h++) begin
          a = c.base_addr + elem_addr_t'(b) * elem_addr_t'(c.surf_stride)
              + elem_addr_t'(h) * elem_addr_t'(c.line_stride);
          r.addr = {a, {ATOM_SHIFT{1'b0}}};
          r.size = req_size_t'(c.width);
          exp_req_q.push_back(r);
          exp_end_q.push_back((b == nblk) && (h == int'(c.height)));
        end
      end
    end
  endtask

  // compare one accepted request with the head of the model queue
  task automatic check_request();
    dma_rd_req_t exp_req;
    logic        exp_end;
    if (exp_req_q.size() == 0) begin
      errors++;
      $display("request accepted with none left in the model at %0t", $time);
    end else begin
      exp_req = exp_req_q.pop_front();
      exp_end = exp_end_q.pop_front();
      assert (dma_rd_req_pd.addr == exp_req.addr)
        else report_mismatch("dma_rd_req_pd.addr", dma_rd_req_pd.addr, exp_req.addr);
      assert (dma_rd_req_pd.size == exp_req.size)
        else report_mismatch("dma_rd_req_pd.size", 64'(dma_rd_req_pd.size), 64'(exp_req.size));
      assert (ig2cq_pd.size == exp_req.size[CQ_SIZE_W-1:0])
        else report_mismatch("ig2cq_pd.size", 64'(ig2cq_pd.size),
                             64'(exp_req.size[CQ_SIZE_W-1:0]));
      assert (ig2cq_pd.cube_end == exp_end)
        else report_mismatch("ig2cq_pd.cube_end", 64'(ig2cq_pd.cube_end), 64'(exp_end));
      // dut goes idle after the model's last request
      if (exp_end) begin
        expect_idle = 1'b1;
      end
    end
    requests++;
  endtask

  // ====================
  // stimulus
  // ====================
  // roughly 3 in 4 cycles ready on each side
  always @(posedge nvdla_core_clk) begin
    draw_bit(rnd_a);
    draw_bit(rnd_b);
    draw_bit(rnd_c);
    draw_bit(rnd_d);
    dma_rd_req_rdy <= rnd_a | rnd_b;
    ig2cq_prdy <= rnd_c | rnd_d;
  end

  task automatic run_op(input mrdma_cfg_t c, input logic perf);
    mrdma_cfg_t lc;
    stall_cnt_t exp_stall;
    lc = c;
    lc.perf_dma_en = perf;
    build_expected(lc);
    @(negedge nvdla_core_clk);
    stall_before = dp2reg_mrdma_stall;
    @(posedge nvdla_core_clk);
    cfg <= lc;
    op_load <= 1'b1;
    expect_idle = 1'b0;
    stall_cycles = '0;
    @(posedge nvdla_core_clk);
    op_load <= 1'b0;
    while (!expect_idle) begin
      @(posedge nvdla_core_clk);
    end
    @(negedge nvdla_core_clk);
    // disabled op leaves the count from before the load
    exp_stall = perf ? stall_cycles : stall_before;
    assert (dp2reg_mrdma_stall == exp_stall)
      else report_mismatch("dp2reg_mrdma_stall", 64'(dp2reg_mrdma_stall), 64'(exp_stall));
    assert (exp_req_q.size() == 0) else begin
      errors++;
      $display("operation ended with %0d requests never issued", exp_req_q.size());
    end
    ops++;
  endtask

  // ====================
  // monitor
  // ====================
  always @(negedge nvdla_core_clk) begin
    if (nvdla_core_rstn) begin
      dma_acc = dma_rd_req_vld && dma_rd_req_rdy;
      cq_acc = ig2cq_pvld && ig2cq_prdy;
      assert (dma_acc == cq_acc) else begin
        errors++;
        $display("dma and queue sides accepted in different cycles at %0t", $time);
      end
      if (expect_idle) begin
        assert (!dma_rd_req_vld && !ig2cq_pvld) else begin
          errors++;
          $display("a valid went high with no operation running at %0t", $time);
        end
      end
      if (dma_rd_req_vld && !dma_rd_req_rdy) begin
        stall_cycles = stall_cycles + stall_cnt_t'(1);
      end
      if (dma_acc) begin
        check_request();
      end
    end
  end

  initial begin
    int total;
    nvdla_core_rstn = 1'b0;
    op_load = 1'b0;
    cfg = '0;
    // normal walks before 1x1 pack
    op_cfg.push_back(make_cfg(60'hc12_3456_789a_bcde, 28'h40, 28'h1234,
                              13'd7, 13'd3, 13'd47, PREC_INT8));
    op_cfg.push_back(make_cfg(60'h000_0000_0fff_fff0, 28'hfff_fff0, 28'h800_0000,
                              13'd15, 13'd2, 13'd23, PREC_INT16));
    op_cfg.push_back(make_cfg(60'h00a_0000_0000_0100, 28'h10, 28'h300,
                              13'd4, 13'd0, 13'd16, PREC_FP16));
    op_cfg.push_back(make_cfg(60'hfff_ffff_ffff_ff00, 28'h20, 28'h200,
                              13'd0, 13'd1, 13'd15, PREC_INT8));
    op_cfg.push_back(make_cfg(60'h123_4567_89ab_cdef, 28'h40, 28'h80,
                              13'd0, 13'd0, 13'd63, PREC_INT8));
    op_cfg.push_back(make_cfg(60'h800_0000_0000_0001, 28'h40, 28'h80,
                              13'd0, 13'd0, 13'd100, PREC_INT16));
    total = 0;
    foreach (op_cfg[i]) begin
      total += 2 * count_requests(op_cfg[i]);
    end
    watchdog_cycles = total * 20 + 200;
    repeat (8) @(posedge nvdla_core_clk);
    nvdla_core_rstn <= 1'b1;
    @(negedge nvdla_core_clk);
    assert (dp2reg_mrdma_stall == '0)
      else report_mismatch("dp2reg_mrdma_stall", 64'(dp2reg_mrdma_stall), 64'h0);
    // each cfg with perf on and then off
    foreach (op_cfg[i]) begin
      run_op(op_cfg[i], 1'b1);
      run_op(op_cfg[i], 1'b0);
    end
    repeat (4) @(posedge nvdla_core_clk);
    $display("ops %0d requests %0d errors %0d", ops, requests, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  // watchdog allows 20 cycles per expected request plus margin
  initial begin
    wait (watchdog_cycles != 0);
    repeat (watchdog_cycles) @(posedge nvdla_core_clk);
    $display("timeout, operations did not finish within %0d cycles", watchdog_cycles);
    $display("Errors found");
    $finish;
  end

endmodule

/* mrdma_ig.f */
verilog/mrdma_ig_pkg.sv
verilog/mrdma_cube_walker.sv
verilog/mrdma_addr_gen.sv
verilog/mrdma_req_issue.sv
verilog/mrdma_stall_cnt.sv
verilog/mrdma_ig.sv
verif/tb_mrdma_ig.sv

/* run_sim.sh */
#!/bin/sh
# compile and run the mrdma_ig testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_mrdma_ig -f mrdma_ig.f -o sim_mrdma_ig
status=$?
if [ $status -ne 0 ]; then
  echo "verilator compile failed with status $status"
  exit 1
fi

out=$(./obj_dir/sim_mrdma_ig)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "No errors"; then
  exit 0
fi
echo "simulation reported failure"
exit 1
